// File: source/core_pkg.sv
package core_pkg;

typedef logic [31:0] word_t;
typedef logic [4:0] reg_idx_t;

localparam word_t reset_pc = 32'h1c00_0000;
// log2 of the byte count, word only
localparam logic [2:0] sz_word = 3'd2;

typedef enum logic [2:0] {
        fwd_gr,
        fwd_ex,
        fwd_mm1,
        fwd_mm2_alu,
        fwd_mm2_mem,
        fwd_wb
} fwd_src_t;

// op_nop must stay at zero, cleared stages decode as nop
typedef enum logic [4:0] {
        op_nop,
        op_add, op_sub, op_and, op_or, op_xor, op_slt, op_sltu,
        op_addi, op_andi, op_ori, op_lu12i,
        op_ld, op_st,
        op_beq, op_bne, op_b, op_bl
} op_t;

typedef struct packed {
        op_t op;
        reg_idx_t rd;
        reg_idx_t rj;
        reg_idx_t rk;
        logic rj_re;
        logic rk_re;
        logic rd_re;
        logic rd_we;
        word_t imm;
        logic is_load;
        logic is_store;
        logic is_branch;
} dec_t;

typedef struct packed {
        word_t pc;
        word_t inst;
        logic valid;
} if_id_t;

typedef struct packed {
        word_t pc;
        dec_t dec;
        word_t rj_val;
        word_t rk_val;
        word_t rd_val;
} id_ex_t;

typedef struct packed {
        word_t pc;
        word_t result;
        word_t addr;
        word_t wdata;
        reg_idx_t rd;
        logic rd_we;
        logic is_load;
        logic is_store;
} ex_mm_t;

typedef struct packed {
        word_t pc;
        reg_idx_t rd;
        logic rd_we;
        word_t wdata;
} mm_wb_t;

endpackage

// File: source/gr.sv
`timescale 1ns/1ps

module gr (
        input  logic clk,
        input  logic rst,
        input  core_pkg::reg_idx_t raddr1,
        input  core_pkg::reg_idx_t raddr2,
        input  core_pkg::reg_idx_t raddr3,
        output core_pkg::word_t rdata1,
        output core_pkg::word_t rdata2,
        output core_pkg::word_t rdata3,
        input  logic we,
        input  core_pkg::reg_idx_t waddr,
        input  core_pkg::word_t wdata
);

import core_pkg::*;

word_t regs [32];

always_ff @(posedge clk) begin
        if (rst) begin
                for (int i = 0; i < 32; i++)
                        regs[i] <= '0;
        end else if (we) begin
                regs[waddr] <= wdata;
        end
end

// no bypass here, wb forwarding covers the write cycle
assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];
assign rdata3 = (raddr3 == '0) ? '0 : regs[raddr3];

endmodule

// File: source/decoder.sv
`timescale 1ns/1ps

module decoder (
        input  core_pkg::word_t inst,
        output core_pkg::dec_t dec
);

import core_pkg::*;

word_t si12;
word_t ui12;
word_t si16;
word_t si26;
word_t si20;

assign si12 = {{20{inst[21]}}, inst[21:10]};
assign ui12 = {20'd0, inst[21:10]};
assign si16 = {{14{inst[25]}}, inst[25:10], 2'b00};
assign si26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
assign si20 = {inst[24:5], 12'd0};

always_comb begin
        dec = '0;
        dec.rd = inst[4:0];
        dec.rj = inst[9:5];
        dec.rk = inst[14:10];
        casez (inst[31:15])
                17'h00020: dec.op = op_add;
                17'h00022: dec.op = op_sub;
                17'h00024: dec.op = op_slt;
                17'h00025: dec.op = op_sltu;
                17'h00029: dec.op = op_and;
                17'h0002a: dec.op = op_or;
                17'h0002b: dec.op = op_xor;
                17'b0000001010???????: dec.op = op_addi;
                17'b0000001101???????: dec.op = op_andi;
                17'b0000001110???????: dec.op = op_ori;
                17'b0001010??????????: dec.op = op_lu12i;
                17'b0010100010???????: dec.op = op_ld;
                17'b0010100110???????: dec.op = op_st;
                17'b010110???????????: dec.op = op_beq;
                17'b010111???????????: dec.op = op_bne;
                17'b010100???????????: dec.op = op_b;
                17'b010101???????????: dec.op = op_bl;
                default: dec.op = op_nop;
        endcase
        case (dec.op)
                op_add, op_sub, op_slt, op_sltu, op_and, op_or, op_xor: begin
                        dec.rj_re = 1'b1;
                        dec.rk_re = 1'b1;
                        dec.rd_we = 1'b1;
                end
                op_addi, op_andi, op_ori, op_ld: begin
                        dec.rj_re = 1'b1;
                        dec.rd_we = 1'b1;
                        dec.imm = (dec.op == op_andi || dec.op == op_ori) ? ui12 : si12;
                        dec.is_load = dec.op == op_ld;
                end
                op_lu12i: begin
                        dec.rd_we = 1'b1;
                        dec.imm = si20;
                end
                op_st: begin
                        dec.rj_re = 1'b1;
                        dec.rd_re = 1'b1;
                        dec.imm = si12;
                        dec.is_store = 1'b1;
                end
                op_beq, op_bne: begin
                        dec.rj_re = 1'b1;
                        dec.rd_re = 1'b1;
                        dec.imm = si16;
                        dec.is_branch = 1'b1;
                end
                op_b, op_bl: begin
                        dec.imm = si26;
                        dec.is_branch = 1'b1;
                        if (dec.op == op_bl) begin
                                // link register
                                dec.rd = 5'd1;
                                dec.rd_we = 1'b1;
                        end
                end
                default: ;
        endcase
        // r0 never counts as a destination
        dec.rd_we = dec.rd_we && dec.rd != '0;
end

endmodule

// File: source/ex_unit.sv
`timescale 1ns/1ps

module ex_unit (
        input  core_pkg::id_ex_t ex,
        output core_pkg::ex_mm_t out,
        output logic branch_taken,
        output core_pkg::word_t branch_target
);

import core_pkg::*;

word_t a;
word_t b;
word_t sum;
word_t result;

assign a = ex.rj_val;
assign b = ex.dec.rk_re ? ex.rk_val : ex.dec.imm;
// also the load/store address, b is the offset there
assign sum = a + b;

always_comb begin
        case (ex.dec.op)
                op_add, op_addi: result = sum;
                op_sub: result = a - b;
                op_slt: result = {31'd0, $signed(a) < $signed(b)};
                op_sltu: result = {31'd0, a < b};
                op_and, op_andi: result = a & b;
                op_or, op_ori: result = a | b;
                op_xor: result = a ^ b;
                op_lu12i: result = ex.dec.imm;
                op_bl: result = ex.pc + 32'd4;
                default: result = '0;
        endcase
end

// beq and bne compare rj against rd
always_comb begin
        case (ex.dec.op)
                op_beq: branch_taken = ex.rj_val == ex.rd_val;
                op_bne: branch_taken = ex.rj_val != ex.rd_val;
                op_b, op_bl: branch_taken = 1'b1;
                default: branch_taken = 1'b0;
        endcase
end

assign branch_target = ex.pc + ex.dec.imm;

assign out.pc = ex.pc;
assign out.result = result;
assign out.addr = sum;
assign out.wdata = ex.rd_val;
assign out.rd = ex.dec.rd;
assign out.rd_we = ex.dec.rd_we;
assign out.is_load = ex.dec.is_load;
assign out.is_store = ex.dec.is_store;

endmodule

// File: source/hazard_ctrl.sv
`timescale 1ns/1ps

module hazard_ctrl (
        input  logic clk,
        input  logic rst,
        input  core_pkg::dec_t id_dec,
        input  core_pkg::reg_idx_t ex_rd,
        input  logic ex_rd_we,
        input  logic ex_load,
        input  core_pkg::reg_idx_t mm1_rd,
        input  logic mm1_rd_we,
        input  logic mm1_load,
        input  core_pkg::reg_idx_t mm2_rd,
        input  logic mm2_rd_we,
        input  logic mm2_load,
        input  logic mm2_hit,
        input  core_pkg::reg_idx_t wb_rd,
        input  logic wb_rd_we,
        input  logic if2_valid,
        input  logic if2_hit,
        input  logic ex_taken,
        output logic pc_wen,
        output logic redirect,
        output logic if1_if2_wen,
        output logic if1_if2_flush,
        output logic if2_id_wen,
        output logic if2_id_flush,
        output logic id_ex_wen,
        output logic id_ex_flush,
        output logic ex_mm1_wen,
        output logic ex_mm1_flush,
        output logic mm1_mm2_wen,
        output logic mm1_mm2_flush,
        output logic mm2_wb_wen,
        output logic mm2_wb_flush,
        output core_pkg::fwd_src_t fwd_j,
        output core_pkg::fwd_src_t fwd_k,
        output core_pkg::fwd_src_t fwd_d
);

import core_pkg::*;

logic started;
logic hold;
logic mem_stall;
logic if_stall;
logic load_use;
logic branch;

// id reads a register that a load ahead of it will write
function automatic logic reads_load(reg_idx_t r, logic pending);
        return pending && ((id_dec.rj_re && id_dec.rj == r) ||
                (id_dec.rk_re && id_dec.rk == r) || (id_dec.rd_re && id_dec.rd == r));
endfunction

// youngest writer wins
function automatic fwd_src_t pick(reg_idx_t r);
        if (ex_rd_we && ex_rd == r)
                return fwd_ex;
        if (mm1_rd_we && mm1_rd == r)
                return fwd_mm1;
        if (mm2_rd_we && mm2_rd == r)
                return mm2_load ? fwd_mm2_mem : fwd_mm2_alu;
        if (wb_rd_we && wb_rd == r)
                return fwd_wb;
        return fwd_gr;
endfunction

// pipeline stays frozen for one cycle after reset
always_ff @(posedge clk) begin
        if (rst)
                started <= 1'b0;
        else
                started <= 1'b1;
end

assign mem_stall = mm2_load && !mm2_hit;
assign if_stall = if2_valid && !if2_hit;

always_comb begin
        load_use = reads_load(ex_rd, ex_rd_we && ex_load) ||
                reads_load(mm1_rd, mm1_rd_we && mm1_load);
end

assign hold = !started || mem_stall;
assign branch = !hold && ex_taken;

assign pc_wen = !hold && (branch || (!load_use && !if_stall));
assign redirect = branch;

assign if1_if2_flush = branch;
assign if1_if2_wen = !hold && !branch && !load_use && !if_stall;
assign if2_id_flush = branch;
assign if2_id_wen = !hold && !branch && !load_use;
assign id_ex_flush = branch || (!hold && load_use);
assign id_ex_wen = !hold && !branch && !load_use;
assign ex_mm1_flush = 1'b0;
assign ex_mm1_wen = !hold;
assign mm1_mm2_flush = 1'b0;
assign mm1_mm2_wen = !hold;
assign mm2_wb_flush = mem_stall;
assign mm2_wb_wen = !hold;

always_comb begin
        fwd_j = pick(id_dec.rj);
        fwd_k = pick(id_dec.rk);
        fwd_d = pick(id_dec.rd);
end

endmodule

// File: source/core.sv
`timescale 1ns/1ps

module core (
        input  logic clk,
        input  logic rst,
        output logic inst_cache_re,
        output core_pkg::word_t inst_cache_raddr,
        input  core_pkg::word_t inst_cache_rdata,
        input  logic inst_cache_hit,
        output logic data_cache_re,
        output logic data_cache_we,
        output core_pkg::word_t data_cache_addr,
        output core_pkg::word_t data_cache_wdata,
        output logic [2:0] data_cache_access_sz,
        input  core_pkg::word_t data_cache_rdata,
        input  logic data_cache_hit,
        output core_pkg::word_t debug_wb_pc,
        output logic [3:0] debug_wb_rf_we,
        output core_pkg::reg_idx_t debug_wb_rf_wnum,
        output core_pkg::word_t debug_wb_rf_wdata
);

import core_pkg::*;

word_t pc;
logic fetch_on;
word_t if1_if2_pc;
logic if1_if2_valid;
if_id_t if2_id;
dec_t dec_raw;
dec_t id_dec;
word_t gr_rj;
word_t gr_rk;
word_t gr_rd;
id_ex_t id_ex_d;
id_ex_t id_ex;
ex_mm_t ex_out;
logic ex_taken;
word_t ex_target;
ex_mm_t ex_mm1;
ex_mm_t mm1_mm2;
ex_mm_t dreq;
mm_wb_t mm2_wb_d;
mm_wb_t mm2_wb;

logic pc_wen, redirect;
logic if1_if2_wen, if1_if2_flush;
logic if2_id_wen, if2_id_flush;
logic id_ex_wen, id_ex_flush;
logic ex_mm1_wen, ex_mm1_flush;
logic mm1_mm2_wen, mm1_mm2_flush;
logic mm2_wb_wen, mm2_wb_flush;
fwd_src_t fwd_j, fwd_k, fwd_d;

function automatic word_t fwd_val(fwd_src_t src, word_t from_gr);
        case (src)
                fwd_ex: return ex_out.result;
                fwd_mm1: return ex_mm1.result;
                fwd_mm2_alu: return mm1_mm2.result;
                fwd_mm2_mem: return data_cache_rdata;
                fwd_wb: return mm2_wb.wdata;
                default: return from_gr;
        endcase
endfunction

hazard_ctrl u_hazard_ctrl (
        .clk(clk),
        .rst(rst),
        .id_dec(id_dec),
        .ex_rd(id_ex.dec.rd),
        .ex_rd_we(id_ex.dec.rd_we),
        .ex_load(id_ex.dec.is_load),
        .mm1_rd(ex_mm1.rd),
        .mm1_rd_we(ex_mm1.rd_we),
        .mm1_load(ex_mm1.is_load),
        .mm2_rd(mm1_mm2.rd),
        .mm2_rd_we(mm1_mm2.rd_we),
        .mm2_load(mm1_mm2.is_load),
        .mm2_hit(data_cache_hit),
        .wb_rd(mm2_wb.rd),
        .wb_rd_we(mm2_wb.rd_we),
        .if2_valid(if1_if2_valid),
        .if2_hit(inst_cache_hit),
        .ex_taken(ex_taken),
        .pc_wen(pc_wen),
        .redirect(redirect),
        .if1_if2_wen(if1_if2_wen),
        .if1_if2_flush(if1_if2_flush),
        .if2_id_wen(if2_id_wen),
        .if2_id_flush(if2_id_flush),
        .id_ex_wen(id_ex_wen),
        .id_ex_flush(id_ex_flush),
        .ex_mm1_wen(ex_mm1_wen),
        .ex_mm1_flush(ex_mm1_flush),
        .mm1_mm2_wen(mm1_mm2_wen),
        .mm1_mm2_flush(mm1_mm2_flush),
        .mm2_wb_wen(mm2_wb_wen),
        .mm2_wb_flush(mm2_wb_flush),
        .fwd_j(fwd_j),
        .fwd_k(fwd_k),
        .fwd_d(fwd_d)
);

always_ff @(posedge clk) begin
        if (rst)
                fetch_on <= 1'b0;
        else
                fetch_on <= 1'b1;
end

always_ff @(posedge clk) begin
        if (rst)
                pc <= reset_pc;
        else if (pc_wen)
                pc <= redirect ? ex_target : pc + 32'd4;
end

// a held if2 entry is fetched again so its data arrives next cycle
assign inst_cache_re = fetch_on;
assign inst_cache_raddr = (if1_if2_valid && !if1_if2_wen) ? if1_if2_pc : pc;

always_ff @(posedge clk) begin
        if (rst || if1_if2_flush) begin
                if1_if2_valid <= 1'b0;
        end else if (if1_if2_wen) begin
                if1_if2_valid <= 1'b1;
                if1_if2_pc <= pc;
        end
end

// a miss leaves an invalid entry in id
always_ff @(posedge clk) begin
        if (rst || if2_id_flush) begin
                if2_id <= '0;
        end else if (if2_id_wen) begin
                if2_id.pc <= if1_if2_pc;
                if2_id.inst <= inst_cache_rdata;
                if2_id.valid <= if1_if2_valid && inst_cache_hit;
        end
end

decoder u_decoder (
        .inst(if2_id.inst),
        .dec(dec_raw)
);

always_comb begin
        if (if2_id.valid)
                id_dec = dec_raw;
        else
                id_dec = '0;
end

gr u_gr (
        .clk(clk),
        .rst(rst),
        .raddr1(id_dec.rj),
        .raddr2(id_dec.rk),
        .raddr3(id_dec.rd),
        .rdata1(gr_rj),
        .rdata2(gr_rk),
        .rdata3(gr_rd),
        .we(mm2_wb.rd_we),
        .waddr(mm2_wb.rd),
        .wdata(mm2_wb.wdata)
);

always_comb begin
        id_ex_d.pc = if2_id.pc;
        id_ex_d.dec = id_dec;
        id_ex_d.rj_val = fwd_val(fwd_j, gr_rj);
        id_ex_d.rk_val = fwd_val(fwd_k, gr_rk);
        id_ex_d.rd_val = fwd_val(fwd_d, gr_rd);
end

always_ff @(posedge clk) begin
        if (rst || id_ex_flush)
                id_ex <= '0;
        else if (id_ex_wen)
                id_ex <= id_ex_d;
end

ex_unit u_ex_unit (
        .ex(id_ex),
        .out(ex_out),
        .branch_taken(ex_taken),
        .branch_target(ex_target)
);

always_ff @(posedge clk) begin
        if (rst || ex_mm1_flush)
                ex_mm1 <= '0;
        else if (ex_mm1_wen)
                ex_mm1 <= ex_out;
end

// while mm2 waits on a load miss its own request is repeated
assign dreq = mm1_mm2_wen ? ex_mm1 : mm1_mm2;
assign data_cache_re = dreq.is_load;
assign data_cache_we = dreq.is_store;
assign data_cache_addr = dreq.addr;
assign data_cache_wdata = dreq.wdata;
assign data_cache_access_sz = sz_word;

always_ff @(posedge clk) begin
        if (rst || mm1_mm2_flush)
                mm1_mm2 <= '0;
        else if (mm1_mm2_wen)
                mm1_mm2 <= ex_mm1;
end

assign mm2_wb_d.pc = mm1_mm2.pc;
assign mm2_wb_d.rd = mm1_mm2.rd;
assign mm2_wb_d.rd_we = mm1_mm2.rd_we;
assign mm2_wb_d.wdata = mm1_mm2.is_load ? data_cache_rdata : mm1_mm2.result;

always_ff @(posedge clk) begin
        if (rst || mm2_wb_flush)
                mm2_wb <= '0;
        else if (mm2_wb_wen)
                mm2_wb <= mm2_wb_d;
end

assign debug_wb_pc = mm2_wb.pc;
assign debug_wb_rf_we = {4{mm2_wb.rd_we}};
assign debug_wb_rf_wnum = mm2_wb.rd;
assign debug_wb_rf_wdata = mm2_wb.wdata;

endmodule

// File: testbench/core_sva.sv
`timescale 1ns/1ps

module core_sva (
        input  logic clk,
        input  logic rst,
        input  logic pc_wen,
        input  logic [5:0] stage_wen,
        input  logic [5:0] stage_flush,
        input  logic inst_cache_re,
        input  core_pkg::word_t inst_cache_raddr,
        input  logic data_cache_re,
        input  logic data_cache_we,
        input  logic [3:0] debug_wb_rf_we
);

// controls settle one cycle into reset
reset_quiet: assert property (@(posedge clk) rst && $past(rst) |->
        !pc_wen && stage_wen == 6'd0 && stage_flush == 6'd0 && !inst_cache_re &&
        !data_cache_re && !data_cache_we && debug_wb_rf_we == 4'd0)
        else $error("pipeline control or cache request active in reset");

fetch_aligned: assert property (@(posedge clk) disable iff (rst)
        inst_cache_re |-> inst_cache_raddr[1:0] == 2'b00)
        else $error("fetch address not word aligned");

wen_flush_exclusive: assert property (@(posedge clk) disable iff (rst)
        (stage_wen & stage_flush) == 6'd0)
        else $error("stage register flushed and written in the same cycle");

endmodule

bind core core_sva u_core_sva (
        .clk(clk),
        .rst(rst),
        .pc_wen(pc_wen),
        .stage_wen({if1_if2_wen, if2_id_wen, id_ex_wen, ex_mm1_wen, mm1_mm2_wen, mm2_wb_wen}),
        .stage_flush({if1_if2_flush, if2_id_flush, id_ex_flush, ex_mm1_flush, mm1_mm2_flush,
                mm2_wb_flush}),
        .inst_cache_re(inst_cache_re),
        .inst_cache_raddr(inst_cache_raddr),
        .data_cache_re(data_cache_re),
        .data_cache_we(data_cache_we),
        .debug_wb_rf_we(debug_wb_rf_we)
);

// File: testbench/tb_core.sv
`timescale 1ns/1ps

module tb_core;

import core_pkg::*;

localparam int prog_len = 200;
localparam int watchdog_ns = prog_len * 40 * 20;
localparam int quiet_cycles = 40;
localparam word_t end_pc = reset_pc + 32'(prog_len - 1) * 32'd4;
// size code is log2 of the byte count, four bytes here
localparam logic [2:0] word_access_sz = 3'd2;

logic clk;
logic rst;
logic inst_cache_re;
word_t inst_cache_raddr;
word_t inst_cache_rdata;
logic inst_cache_hit;
logic data_cache_re;
logic data_cache_we;
word_t data_cache_addr;
word_t data_cache_wdata;
logic [2:0] data_cache_access_sz;
word_t data_cache_rdata;
logic data_cache_hit;
word_t debug_wb_pc;
logic [3:0] debug_wb_rf_we;
reg_idx_t debug_wb_rf_wnum;
word_t debug_wb_rf_wdata;

op_t alu_ops [7] = '{op_add, op_sub, op_and, op_or, op_xor, op_slt, op_sltu};
op_t gen_op [prog_len];
reg_idx_t gen_rd [prog_len];
reg_idx_t gen_rj [prog_len];
reg_idx_t gen_rk [prog_len];
word_t gen_imm [prog_len];
word_t imem [256];
word_t dmem [64];
word_t iss_mem [64];
word_t exp_pc [$];
reg_idx_t exp_num [$];
word_t exp_data [$];
int exp_stores;
int n_stores;
int n_ret;
int cycle;
int mismatches;
int other_errors;
logic end_fetched;
logic fetch_seen;

core UUT (
        .clk(clk),
        .rst(rst),
        .inst_cache_re(inst_cache_re),
        .inst_cache_raddr(inst_cache_raddr),
        .inst_cache_rdata(inst_cache_rdata),
        .inst_cache_hit(inst_cache_hit),
        .data_cache_re(data_cache_re),
        .data_cache_we(data_cache_we),
        .data_cache_addr(data_cache_addr),
        .data_cache_wdata(data_cache_wdata),
        .data_cache_access_sz(data_cache_access_sz),
        .data_cache_rdata(data_cache_rdata),
        .data_cache_hit(data_cache_hit),
        .debug_wb_pc(debug_wb_pc),
        .debug_wb_rf_we(debug_wb_rf_we),
        .debug_wb_rf_wnum(debug_wb_rf_wnum),
        .debug_wb_rf_wdata(debug_wb_rf_wdata)
);

always #10 clk = ~clk;

// dependencies stay dense in r1..r7
function automatic reg_idx_t rand_reg();
        if ($urandom % 8 == 0)
                return reg_idx_t'($urandom % 32);
        return reg_idx_t'(1 + $urandom % 7);
endfunction

function automatic word_t fill_value(int i);
        return (32'(i) << 2) * 32'h9e37_79b9 + 32'h3c6e_f372;
endfunction

// LoongArch-32 encodings, branch offsets in words
function automatic word_t encode(op_t op, reg_idx_t rd, reg_idx_t rj, reg_idx_t rk, word_t imm);
        case (op)
                op_add: return {17'h00020, rk, rj, rd};
                op_sub: return {17'h00022, rk, rj, rd};
                op_slt: return {17'h00024, rk, rj, rd};
                op_sltu: return {17'h00025, rk, rj, rd};
                op_and: return {17'h00029, rk, rj, rd};
                op_or: return {17'h0002a, rk, rj, rd};
                op_xor: return {17'h0002b, rk, rj, rd};
                op_addi: return {10'h00a, imm[11:0], rj, rd};
                op_andi: return {10'h00d, imm[11:0], rj, rd};
                op_ori: return {10'h00e, imm[11:0], rj, rd};
                op_ld: return {10'h0a2, imm[11:0], rj, rd};
                op_st: return {10'h0a6, imm[11:0], rj, rd};
                op_lu12i: return {7'h0a, imm[19:0], rd};
                op_beq: return {6'h16, imm[15:0], rj, rd};
                op_bne: return {6'h17, imm[15:0], rj, rd};
                op_b: return {6'h14, imm[15:0], imm[25:16]};
                op_bl: return {6'h15, imm[15:0], imm[25:16]};
                default: return '0;
        endcase
endfunction

task automatic make_program();
        op_t op;
        reg_idx_t rd;
        reg_idx_t rj;
        word_t imm;
        int span;
        for (int i = 0; i < prog_len; i++) begin
                rd = rand_reg();
                rj = rand_reg();
                imm = $urandom;
                span = (prog_len - 1 - i < 8) ? prog_len - 1 - i : 8;
                if (i == prog_len - 1) begin
                        // end loop
                        op = op_b;
                        imm = '0;
                end else begin
                        case ($urandom % 20)
                                0, 1, 2, 3, 4, 5, 6: op = alu_ops[3'($urandom % 7)];
                                7, 8: op = op_addi;
                                9: op = op_andi;
                                10: op = op_ori;
                                11: op = op_lu12i;
                                12, 13: op = op_ld;
                                14, 15: op = op_st;
                                16: op = op_beq;
                                17: op = op_bne;
                                18: op = op_b;
                                default: op = op_bl;
                        endcase
                        if (op == op_ld || op == op_st) begin
                                rj = '0;
                                imm = word_t'($urandom % 64) << 2;
                        end
                        if (op == op_beq || op == op_bne || op == op_b || op == op_bl)
                                imm = word_t'(1 + $urandom % span);
                end
                gen_op[i] = op;
                gen_rd[i] = rd;
                gen_rj[i] = rj;
                gen_rk[i] = rand_reg();
                gen_imm[i] = imm;
                imem[i] = encode(op, rd, rj, gen_rk[i], imm);
        end
endtask

// reference ISS, runs the program once before reset is released
task automatic run_iss();
        word_t iss_regs [32];
        word_t pc;
        word_t a;
        word_t k;
        word_t d;
        word_t val;
        word_t addr;
        reg_idx_t dest;
        int idx;
        int next;
        logic wr;
        for (int r = 0; r < 32; r++)
                iss_regs[r] = '0;
        idx = 0;
        while (idx < prog_len - 1) begin
                pc = reset_pc + 32'(idx) * 32'd4;
                a = iss_regs[gen_rj[idx]];
                k = iss_regs[gen_rk[idx]];
                d = iss_regs[gen_rd[idx]];
                addr = a + {{20{gen_imm[idx][11]}}, gen_imm[idx][11:0]};
                next = idx + 1;
                wr = 1'b1;
                val = '0;
                case (gen_op[idx])
                        op_add: val = a + k;
                        op_sub: val = a - k;
                        op_and: val = a & k;
                        op_or: val = a | k;
                        op_xor: val = a ^ k;
                        op_slt: val = ($signed(a) < $signed(k)) ? 32'd1 : 32'd0;
                        op_sltu: val = (a < k) ? 32'd1 : 32'd0;
                        op_addi: val = addr;
                        op_andi: val = a & {20'd0, gen_imm[idx][11:0]};
                        op_ori: val = a | {20'd0, gen_imm[idx][11:0]};
                        op_lu12i: val = {gen_imm[idx][19:0], 12'd0};
                        op_ld: val = iss_mem[addr[7:2]];
                        op_st: begin
                                iss_mem[addr[7:2]] = d;
                                exp_stores++;
                                wr = 1'b0;
                        end
                        op_beq: begin
                                wr = 1'b0;
                                if (a == d)
                                        next = idx + int'(gen_imm[idx]);
                        end
                        op_bne: begin
                                wr = 1'b0;
                                if (a != d)
                                        next = idx + int'(gen_imm[idx]);
                        end
                        op_b: begin
                                wr = 1'b0;
                                next = idx + int'(gen_imm[idx]);
                        end
                        op_bl: begin
                                val = pc + 32'd4;
                                next = idx + int'(gen_imm[idx]);
                        end
                        default: wr = 1'b0;
                endcase
                dest = (gen_op[idx] == op_bl) ? 5'd1 : gen_rd[idx];
                if (wr && dest != 5'd0) begin
                        iss_regs[dest] = val;
                        exp_pc.push_back(pc);
                        exp_num.push_back(dest);
                        exp_data.push_back(val);
                end
                idx = next;
        end
endtask

task automatic check_retire();
        assert (n_ret < exp_pc.size()) else begin
                other_errors++;
                $display("ERROR at %0t: more register writes retired than expected", $time);
        end
        if (n_ret < exp_pc.size()) begin
                assert (debug_wb_pc == exp_pc[n_ret] && debug_wb_rf_wnum == exp_num[n_ret] &&
                        debug_wb_rf_wdata == exp_data[n_ret]) else begin
                        mismatches++;
                        $display("MISMATCH at %0t: write %0d pc %h r%0d=%h, expected pc %h r%0d=%h",
                                $time, n_ret, debug_wb_pc, debug_wb_rf_wnum, debug_wb_rf_wdata,
                                exp_pc[n_ret], exp_num[n_ret], exp_data[n_ret]);
                end
        end
        n_ret++;
endtask

task automatic report_counts();
        $display("mismatches %0d, other errors %0d, retired writes %0d of %0d",
                mismatches, other_errors, n_ret, exp_pc.size());
endtask

// synchronous instruction and data memories, 75 percent hit rate
always @(posedge clk) begin
        if (inst_cache_re) begin
                inst_cache_rdata <= imem[inst_cache_raddr[9:2] - reset_pc[9:2]];
                inst_cache_hit <= ($urandom % 4) != 0;
                if (inst_cache_raddr == end_pc)
                        end_fetched = 1'b1;
        end else begin
                inst_cache_hit <= 1'b0;
        end
        if (data_cache_re || data_cache_we) begin
                assert (data_cache_access_sz == word_access_sz) else begin
                        mismatches++;
                        $display("MISMATCH at %0t: data access size %0d, expected %0d",
                                $time, data_cache_access_sz, word_access_sz);
                end
        end
        if (data_cache_we) begin
                dmem[data_cache_addr[7:2]] <= data_cache_wdata;
                n_stores++;
        end
        if (data_cache_re) begin
                data_cache_rdata <= dmem[data_cache_addr[7:2]];
                data_cache_hit <= ($urandom % 4) != 0;
        end else begin
                data_cache_hit <= 1'b0;
        end
end

always @(posedge clk) begin
        if (rst) begin
                if (cycle > 0) begin
                        assert (!inst_cache_re && !data_cache_re && !data_cache_we &&
                                debug_wb_rf_we == 4'd0) else begin
                                other_errors++;
                                $display("ERROR at %0t: cache request or register write in reset",
                                        $time);
                        end
                end
        end else begin
                if (inst_cache_re && !fetch_seen) begin
                        fetch_seen = 1'b1;
                        assert (inst_cache_raddr == reset_pc) else begin
                                mismatches++;
                                $display("MISMATCH at %0t: first fetch at %h, expected %h",
                                        $time, inst_cache_raddr, reset_pc);
                        end
                end
                if (debug_wb_rf_we != 4'd0 && debug_wb_rf_wnum != 5'd0)
                        check_retire();
        end
        cycle++;
end

initial begin
        #(watchdog_ns);
        $display("ERROR: timeout, the core did not reach the end of the program");
        report_counts();
        $display("CHECKS FAILED");
        $finish;
end

initial begin
        void'($urandom(32'he6cc));
        clk = 1'b0;
        rst <= 1'b1;
        inst_cache_rdata <= '0;
        inst_cache_hit <= 1'b0;
        data_cache_rdata <= '0;
        data_cache_hit <= 1'b0;
        end_fetched = 1'b0;
        fetch_seen = 1'b0;
        for (int i = 0; i < 256; i++)
                imem[i] = '0;
        for (int i = 0; i < 64; i++) begin
                dmem[i] <= fill_value(i);
                iss_mem[i] = fill_value(i);
        end
        make_program();
        run_iss();
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        while (!(n_ret >= exp_pc.size() && n_stores >= exp_stores && end_fetched))
                @(posedge clk);
        // window for stray writes after the last expected one
        repeat (quiet_cycles) @(posedge clk);
        for (int i = 0; i < 64; i++) begin
                assert (dmem[i] == iss_mem[i]) else begin
                        mismatches++;
                        $display("MISMATCH at %0t: data word %0d is %h, expected %h",
                                $time, i, dmem[i], iss_mem[i]);
                end
        end
        assert (n_ret == exp_pc.size()) else begin
                other_errors++;
                $display("ERROR: retired write count differs from the reference trace");
        end
        report_counts();
        if (mismatches == 0 && other_errors == 0)
                $display("ALL CHECKS PASSED");
        else
                $display("CHECKS FAILED");
        $finish;
end

endmodule

// File: list.f
source/core_pkg.sv
source/gr.sv
source/decoder.sv
source/ex_unit.sv
source/hazard_ctrl.sv
source/core.sv
testbench/core_sva.sv
testbench/tb_core.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module tb_core -f list.f > build.log 2>&1 &&
        ./obj_dir/Vtb_core > sim.log 2>&1 ||
        echo "build or simulation ended with an error, see build.log and sim.log"
grep -qx "ALL CHECKS PASSED" sim.log && echo "simulation passed" ||
        { echo "simulation failed"; exit 1; }
